//--- sources.f
common/wb_pkg.sv
wb_stage/wb_lane_select.sv
wb_stage/exc_commit.sv
wb_stage/wb_trace.sv
verilog/wb_top.sv
testbench/wb_top_assert.sv
testbench/wb_checker.sv
testbench/tb_wb_top.sv

//--- Bender.yml
package:
  name: wb_stage

sources:
  - common/wb_pkg.sv
  - wb_stage/wb_lane_select.sv
  - wb_stage/exc_commit.sv
  - wb_stage/wb_trace.sv
  - verilog/wb_top.sv
  - target: test
    files:
      - testbench/wb_top_assert.sv
      - testbench/wb_checker.sv
      - testbench/tb_wb_top.sv

//--- testbench/tb_wb_top.sv
`timescale 1ns/1ps

module tb_wb_top;
    import wb_pkg::*;

    localparam int trace_wen_w = 4;
    localparam int n_bundles   = 400;
    // longest accept wait before the run is abandoned
    localparam int wait_limit  = 50;

    logic                   clk;
    logic                   aresetn;
    issue_t                 lane0;
    issue_t                 lane1;
    exc_in_t                exc;
    logic                   cpu_interrupt;
    logic [xlen-1:0]        dcache_data;
    logic                   dcache_ready;
    logic [xlen-1:0]        csr_data;
    logic [xlen-1:0]        eentry;
    logic [xlen-1:0]        tlbrentry;
    logic                   allowin;
    wb_write_t              wr0;
    wb_write_t              wr1;
    exc_commit_t            commit;
    logic [xlen-1:0]        redirect_pc;
    logic [xlen-1:0]        trace0_pc;
    logic [xlen-1:0]        trace0_inst;
    logic [trace_wen_w-1:0] trace0_wen;
    logic [reg_addr_w-1:0]  trace0_wnum;
    logic [xlen-1:0]        trace0_wdata;
    logic                   trace0_valid;
    logic [xlen-1:0]        trace1_pc;
    logic [xlen-1:0]        trace1_inst;
    logic [trace_wen_w-1:0] trace1_wen;
    logic [reg_addr_w-1:0]  trace1_wnum;
    logic [xlen-1:0]        trace1_wdata;
    logic                   trace1_valid;

    integer seed;
    int     stall_len;
    int     mismatch_count;
    int     timeout_count;

    // synchronous exception codes only
    // interrupts come in on their own pin
    logic [ecode_w-1:0] codes [11] = '{exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi,
        exp_adef, exp_ale, exp_tlbr, exp_sys, exp_brk, exp_ine};

    wb_top #(.trace_wen_w(trace_wen_w)) dut0 (.*);

    wb_checker #(.trace_wen_w(trace_wen_w)) chk0 (.*, .error_count(mismatch_count));

    bind wb_top wb_top_assert u_assert (
        .clk    (clk),
        .aresetn(aresetn),
        .allowin(allowin),
        .wr0    (wr0),
        .wr1    (wr1),
        .commit (commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random lane bundle that is mostly valid
    function automatic issue_t random_lane();
        issue_t l;
        l.valid  = ($random(seed) & 7) != 0;
        l.pc     = $random(seed) & 32'hffff_fffc;
        l.inst   = $random(seed);
        l.rd     = 5'($random(seed));
        l.kind   = src_kind_t'(2'($random(seed)));
        l.result = $random(seed);
        return l;
    endfunction

    // fresh bundles, a rare trap, and how long the dcache stays busy
    task automatic drive_bundles();
        issue_t  l0;
        exc_in_t e;
        int      r;
        l0      = random_lane();
        r       = $random(seed) & 63;
        e.valid = r < 3;
        e.ecode = codes[$unsigned($random(seed)) % 11];
        e.badv  = $random(seed);
        lane0         <= l0;
        lane1         <= random_lane();
        exc           <= e;
        cpu_interrupt <= (r == 63);
        dcache_data   <= $random(seed);
        csr_data      <= $random(seed);
        stall_len = (l0.valid && l0.kind == src_load) ? ($random(seed) & 7) : 0;
        dcache_ready  <= (stall_len == 0);
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 mismatch_count, dut0.u_assert.fail_count, timeout_count);
    endtask

    // step to the edge that takes the bundles, raising dcache_ready after the wait
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!allowin) begin
            cycles++;
            if (cycles == stall_len)
                dcache_ready <= 1'b1;
            if (cycles > wait_limit) begin
                timeout_count++;
                $display("Timeout at %0t ns: bundles were not taken within %0d cycles",
                         $time, wait_limit);
                print_counts();
                $display("Simulation failed");
                $finish;
            end
            @(posedge clk);
        end
    endtask

    initial begin
        seed          = 32'hc341e57a;
        timeout_count = 0;
        aresetn       = 1'b0;
        lane0         = '0;
        lane1         = '0;
        exc           = '0;
        cpu_interrupt = 1'b0;
        dcache_data   = '0;
        dcache_ready  = 1'b1;
        csr_data      = '0;
        eentry        = 32'h1c00_8000;
        tlbrentry     = 32'h1c00_f000;
        repeat (8) @(posedge clk);
        aresetn <= 1'b1;
        repeat (n_bundles) begin
            drive_bundles();
            wait_accept();
        end
        // idle inputs so the last writes and traces drain
        lane0         <= '0;
        lane1         <= '0;
        exc           <= '0;
        cpu_interrupt <= 1'b0;
        dcache_ready  <= 1'b1;
        repeat (4) @(posedge clk);
        print_counts();
        if (mismatch_count == 0 && timeout_count == 0 && dut0.u_assert.fail_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- testbench/wb_checker.sv
`timescale 1ns/1ps

module wb_checker #(
    parameter int trace_wen_w = 4
) (
    input  logic                          clk,
    input  logic                          aresetn,
    input  wb_pkg::issue_t                lane0,
    input  wb_pkg::issue_t                lane1,
    input  wb_pkg::exc_in_t               exc,
    input  logic                          cpu_interrupt,
    input  logic [wb_pkg::xlen-1:0]       dcache_data,
    input  logic                          dcache_ready,
    input  logic [wb_pkg::xlen-1:0]       csr_data,
    input  logic [wb_pkg::xlen-1:0]       eentry,
    input  logic [wb_pkg::xlen-1:0]       tlbrentry,
    input  logic                          allowin,
    input  wb_pkg::wb_write_t             wr0,
    input  wb_pkg::wb_write_t             wr1,
    input  wb_pkg::exc_commit_t           commit,
    input  logic [wb_pkg::xlen-1:0]       redirect_pc,
    input  logic [wb_pkg::xlen-1:0]       trace0_pc,
    input  logic [wb_pkg::xlen-1:0]       trace0_inst,
    input  logic [trace_wen_w-1:0]        trace0_wen,
    input  logic [wb_pkg::reg_addr_w-1:0] trace0_wnum,
    input  logic [wb_pkg::xlen-1:0]       trace0_wdata,
    input  logic                          trace0_valid,
    input  logic [wb_pkg::xlen-1:0]       trace1_pc,
    input  logic [wb_pkg::xlen-1:0]       trace1_inst,
    input  logic [trace_wen_w-1:0]        trace1_wen,
    input  logic [wb_pkg::reg_addr_w-1:0] trace1_wnum,
    input  logic [wb_pkg::xlen-1:0]       trace1_wdata,
    input  logic                          trace1_valid,
    output int                            error_count
);
    import wb_pkg::*;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
        logic [reg_addr_w-1:0] wnum;
        logic [xlen-1:0]       wdata;
    } trace_t;

    // expectations for the outputs after the last edge
    wb_write_t       exp_wr [2];
    trace_t          exp_tr [2];
    exc_commit_t     exp_cm;
    // pc and inst of the bundle seen at the last edge
    logic [xlen-1:0] last_pc [2];
    logic [xlen-1:0] last_inst [2];
    // flush was showing at the last edge
    logic            tr_flush = 1'b0;
    logic            primed = 1'b0;
    int              errors = 0;

    assign error_count = errors;

    // address faults latch badv
    function automatic logic writes_badv(input logic [ecode_w-1:0] code);
        case (code)
            exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi, exp_adef, exp_ale, exp_tlbr:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // same set minus the non tlb address errors
    function automatic logic writes_vppn(input logic [ecode_w-1:0] code);
        if (code == exp_adef || code == exp_ale)
            return 1'b0;
        return writes_badv(code);
    endfunction

    function automatic logic [xlen-1:0] expected_value(input issue_t l,
                                                      input logic [xlen-1:0] ld,
                                                      input logic [xlen-1:0] csr);
        case (l.kind)
            src_link: return l.result + 32'd4;
            src_load: return ld;
            src_csr:  return csr;
            default:  return l.result;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, want, got);
        end
    endtask

    // inputs and outputs both read before this edge's updates land
    always @(posedge clk) begin : compare_and_step
        wb_write_t              got_wr [2];
        trace_t                 got_tr [2];
        logic [trace_wen_w-1:0] got_wen [2];
        issue_t                 lane [2];
        logic                   allow;
        logic                   trap;
        logic [ecode_w-1:0]     code;
        got_wr[0]  = wr0;
        got_wr[1]  = wr1;
        got_tr[0]  = '{trace0_valid, trace0_pc, trace0_inst, trace0_wnum, trace0_wdata};
        got_tr[1]  = '{trace1_valid, trace1_pc, trace1_inst, trace1_wnum, trace1_wdata};
        got_wen[0] = trace0_wen;
        got_wen[1] = trace1_wen;
        lane[0]    = lane0;
        lane[1]    = lane1;
        // only a waiting lane 0 load holds the upstream stage
        allow = !(lane0.valid && lane0.kind == src_load && !dcache_ready);
        check_value("allowin", allowin, allow);
        if (primed) begin
            for (int i = 0; i < 2; i++) begin
                check_value($sformatf("wr%0d.we", i), got_wr[i].we, exp_wr[i].we);
                if (exp_wr[i].we) begin
                    check_value($sformatf("wr%0d.rd", i), got_wr[i].rd, exp_wr[i].rd);
                    check_value($sformatf("wr%0d.data", i), got_wr[i].data, exp_wr[i].data);
                end
                check_value($sformatf("trace%0d_valid", i), got_tr[i].valid, exp_tr[i].valid);
                if (exp_tr[i].valid || tr_flush)
                    check_value($sformatf("trace%0d_inst", i), got_tr[i].inst,
                                exp_tr[i].inst);
                if (exp_tr[i].valid) begin
                    check_value($sformatf("trace%0d_pc", i), got_tr[i].pc, exp_tr[i].pc);
                    check_value($sformatf("trace%0d_wnum", i), got_tr[i].wnum, exp_tr[i].wnum);
                    check_value($sformatf("trace%0d_wdata", i), got_tr[i].wdata,
                                exp_tr[i].wdata);
                    check_value($sformatf("trace%0d_wen", i), got_wen[i], 1);
                end
            end
            check_value("commit.flush", commit.flush, exp_cm.flush);
            check_value("commit.wen_era", commit.wen_era, exp_cm.wen_era);
            check_value("commit.wen_badv", commit.wen_badv, exp_cm.wen_badv);
            check_value("commit.wen_vppn", commit.wen_vppn, exp_cm.wen_vppn);
            check_value("commit.tlb_refill", commit.tlb_refill, exp_cm.tlb_refill);
            if (exp_cm.flush) begin
                check_value("commit.ecode", commit.ecode, exp_cm.ecode);
                check_value("commit.era", commit.era, exp_cm.era);
                check_value("commit.is_int", commit.is_int, exp_cm.is_int);
            end
            if (exp_cm.wen_badv)
                check_value("commit.badv", commit.badv, exp_cm.badv);
            if (exp_cm.wen_vppn)
                check_value("commit.vppn", commit.vppn, exp_cm.vppn);
            check_value("redirect_pc", redirect_pc, exp_cm.tlb_refill ? tlbrentry : eentry);
        end
        // a flush showing now puts a nop in both instruction slots
        tr_flush = aresetn && exp_cm.flush;
        // trace echoes last edge's writes unless a flush is showing now
        for (int i = 0; i < 2; i++) begin
            exp_tr[i].valid = aresetn && !exp_cm.flush && exp_wr[i].we;
            exp_tr[i].pc    = last_pc[i];
            exp_tr[i].inst  = tr_flush ? inst_nop : last_inst[i];
            exp_tr[i].wnum  = exp_wr[i].rd;
            exp_tr[i].wdata = exp_wr[i].data;
        end
        trap = aresetn && (exc.valid || cpu_interrupt);
        // trap now or flush from last edge kills both lanes
        for (int i = 0; i < 2; i++) begin
            exp_wr[i].we   = aresetn && lane[i].valid && allow && !trap && !exp_cm.flush &&
                             !(i == 1 && lane[i].kind == src_load);
            exp_wr[i].rd   = lane[i].rd;
            exp_wr[i].data = expected_value(lane[i], dcache_data, csr_data);
            last_pc[i]     = lane[i].pc;
            last_inst[i]   = lane[i].inst;
        end
        code              = cpu_interrupt ? exp_int : exc.ecode;
        exp_cm.flush      = trap;
        exp_cm.wen_era    = trap;
        exp_cm.wen_badv   = trap && writes_badv(code);
        exp_cm.wen_vppn   = trap && writes_vppn(code);
        exp_cm.tlb_refill = trap && (code == exp_tlbr);
        exp_cm.is_int     = cpu_interrupt;
        exp_cm.era        = lane0.pc;
        exp_cm.ecode      = code;
        exp_cm.badv       = exc.badv;
        exp_cm.vppn       = exc.badv[31:13];
        primed = 1'b1;
    end

endmodule

//--- testbench/wb_top_assert.sv
`timescale 1ns/1ps

module wb_top_assert (
    input logic                clk,
    input logic                aresetn,
    input logic                allowin,
    input wb_pkg::wb_write_t   wr0,
    input wb_pkg::wb_write_t   wr1,
    input wb_pkg::exc_commit_t commit
);

    // failed assertion count
    int fail_count = 0;

    // sync reset clears writes and flush one edge later
    reset_clears: assert property (@(posedge clk)
        !aresetn |=> !wr0.we && !wr1.we && !commit.flush)
        else begin
            fail_count++;
            $error("write enable or flush still set after a reset edge");
        end

    // stalled load blocks both lanes
    stall_blocks: assert property (@(posedge clk) disable iff (!aresetn)
        !allowin |=> !wr0.we && !wr1.we)
        else begin
            fail_count++;
            $error("register write after a cycle with allowin low");
        end

    // flush cycle commits nothing
    flush_blocks: assert property (@(posedge clk) disable iff (!aresetn)
        commit.flush |=> !wr0.we && !wr1.we)
        else begin
            fail_count++;
            $error("register write after a flush cycle");
        end

endmodule

//--- verilog/wb_top.sv
`timescale 1ns/1ps

module wb_top #(
    parameter int trace_wen_w = 4
) (
    input  logic                    clk,
    input  logic                    aresetn,
    input  wb_pkg::issue_t          lane0,
    input  wb_pkg::issue_t          lane1,
    input  wb_pkg::exc_in_t         exc,
    input  logic                    cpu_interrupt,
    input  logic [wb_pkg::xlen-1:0] dcache_data,
    input  logic                    dcache_ready,
    input  logic [wb_pkg::xlen-1:0] csr_data,
    input  logic [wb_pkg::xlen-1:0] eentry,
    input  logic [wb_pkg::xlen-1:0] tlbrentry,
    output logic                    allowin,
    output wb_pkg::wb_write_t       wr0,
    output wb_pkg::wb_write_t       wr1,
    output wb_pkg::exc_commit_t     commit,
    output logic [wb_pkg::xlen-1:0] redirect_pc,
    output logic [wb_pkg::xlen-1:0] trace0_pc,
    output logic [wb_pkg::xlen-1:0] trace0_inst,
    output logic [trace_wen_w-1:0]  trace0_wen,
    output logic [wb_pkg::reg_addr_w-1:0] trace0_wnum,
    output logic [wb_pkg::xlen-1:0] trace0_wdata,
    output logic                    trace0_valid,
    output logic [wb_pkg::xlen-1:0] trace1_pc,
    output logic [wb_pkg::xlen-1:0] trace1_inst,
    output logic [trace_wen_w-1:0]  trace1_wen,
    output logic [wb_pkg::reg_addr_w-1:0] trace1_wnum,
    output logic [wb_pkg::xlen-1:0] trace1_wdata,
    output logic                    trace1_valid
);
    import wb_pkg::*;

    // registered pc and inst, lane select to trace
    logic [xlen-1:0] pc0_q;
    logic [xlen-1:0] inst0_q;
    logic [xlen-1:0] pc1_q;
    logic [xlen-1:0] inst1_q;

    // value mux, load stall and write enables
    wb_lane_select u_lane_select (
        .clk          (clk),
        .aresetn      (aresetn),
        .lane0        (lane0),
        .lane1        (lane1),
        .exc_valid    (exc.valid),
        .cpu_interrupt(cpu_interrupt),
        .flush        (commit.flush),
        .dcache_data  (dcache_data),
        .dcache_ready (dcache_ready),
        .csr_data     (csr_data),
        .allowin      (allowin),
        .wr0          (wr0),
        .wr1          (wr1),
        .pc0_q        (pc0_q),
        .inst0_q      (inst0_q),
        .pc1_q        (pc1_q),
        .inst1_q      (inst1_q)
    );

    // era comes from lane 0 pc of the trapping cycle
    exc_commit u_exc_commit (
        .clk          (clk),
        .aresetn      (aresetn),
        .exc          (exc),
        .cpu_interrupt(cpu_interrupt),
        .pc0          (lane0.pc),
        .eentry       (eentry),
        .tlbrentry    (tlbrentry),
        .commit       (commit),
        .redirect_pc  (redirect_pc)
    );

    wb_trace #(
        .trace_wen_w(trace_wen_w)
    ) u_trace (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (commit.flush),
        .wr0         (wr0),
        .wr1         (wr1),
        .pc0         (pc0_q),
        .inst0       (inst0_q),
        .pc1         (pc1_q),
        .inst1       (inst1_q),
        .trace0_pc   (trace0_pc),
        .trace0_inst (trace0_inst),
        .trace0_wen  (trace0_wen),
        .trace0_wnum (trace0_wnum),
        .trace0_wdata(trace0_wdata),
        .trace0_valid(trace0_valid),
        .trace1_pc   (trace1_pc),
        .trace1_inst (trace1_inst),
        .trace1_wen  (trace1_wen),
        .trace1_wnum (trace1_wnum),
        .trace1_wdata(trace1_wdata),
        .trace1_valid(trace1_valid)
    );

endmodule

//--- wb_stage/wb_trace.sv
`timescale 1ns/1ps

module wb_trace #(
    parameter int trace_wen_w = 4
) (
    input  logic                    clk,
    input  logic                    aresetn,
    input  logic                    flush,
    input  wb_pkg::wb_write_t       wr0,
    input  wb_pkg::wb_write_t       wr1,
    input  logic [wb_pkg::xlen-1:0] pc0,
    input  logic [wb_pkg::xlen-1:0] inst0,
    input  logic [wb_pkg::xlen-1:0] pc1,
    input  logic [wb_pkg::xlen-1:0] inst1,
    output logic [wb_pkg::xlen-1:0] trace0_pc,
    output logic [wb_pkg::xlen-1:0] trace0_inst,
    output logic [trace_wen_w-1:0]  trace0_wen,
    output logic [wb_pkg::reg_addr_w-1:0] trace0_wnum,
    output logic [wb_pkg::xlen-1:0] trace0_wdata,
    output logic                    trace0_valid,
    output logic [wb_pkg::xlen-1:0] trace1_pc,
    output logic [wb_pkg::xlen-1:0] trace1_inst,
    output logic [trace_wen_w-1:0]  trace1_wen,
    output logic [wb_pkg::reg_addr_w-1:0] trace1_wnum,
    output logic [wb_pkg::xlen-1:0] trace1_wdata,
    output logic                    trace1_valid
);
    import wb_pkg::*;

    logic [trace_wen_w-1:0] wen0_next;
    logic [trace_wen_w-1:0] wen1_next;

    // byte-enable style wen, only bit 0 carries the write
    always_comb begin
        wen0_next    = '0;
        wen1_next    = '0;
        wen0_next[0] = wr0.we;
        wen1_next[0] = wr1.we;
    end

    // valids follow the committed writes
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            trace0_valid <= 1'b0;
            trace1_valid <= 1'b0;
        end else if (flush) begin
            trace0_valid <= 1'b0;
            trace1_valid <= 1'b0;
        end else begin
            trace0_valid <= wr0.we;
            trace1_valid <= wr1.we;
        end
    end

    // trace payload
    always_ff @(posedge clk) begin
        trace0_pc    <= pc0;
        trace1_pc    <= pc1;
        // show a nop on the flushed slot
        trace0_inst  <= flush ? inst_nop : inst0;
        trace1_inst  <= flush ? inst_nop : inst1;
        trace0_wen   <= wen0_next;
        trace1_wen   <= wen1_next;
        trace0_wnum  <= wr0.rd;
        trace1_wnum  <= wr1.rd;
        trace0_wdata <= wr0.data;
        trace1_wdata <= wr1.data;
    end

endmodule

//--- wb_stage/exc_commit.sv
`timescale 1ns/1ps

module exc_commit (
    input  logic                    clk,
    input  logic                    aresetn,
    input  wb_pkg::exc_in_t         exc,
    input  logic                    cpu_interrupt,
    input  logic [wb_pkg::xlen-1:0] pc0,
    input  logic [wb_pkg::xlen-1:0] eentry,
    input  logic [wb_pkg::xlen-1:0] tlbrentry,
    output wb_pkg::exc_commit_t     commit,
    output logic [wb_pkg::xlen-1:0] redirect_pc
);
    import wb_pkg::*;

    logic               exc_any;
    logic [ecode_w-1:0] code;

    // any trap on lane 0 this cycle
    assign exc_any = exc.valid | cpu_interrupt;

    // interrupt wins over a synchronous exception
    assign code = cpu_interrupt ? exp_int : exc.ecode;

    // control bits of the record
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            commit.flush      <= 1'b0;
            commit.wen_era    <= 1'b0;
            commit.wen_badv   <= 1'b0;
            commit.wen_vppn   <= 1'b0;
            commit.tlb_refill <= 1'b0;
            commit.is_int     <= 1'b0;
        end else begin
            commit.flush   <= exc_any;
            commit.wen_era <= exc_any;
            // exp_int is in neither set, so an interrupt writes no badv
            commit.wen_badv   <= exc_any & is_badv_code(code);
            commit.wen_vppn   <= exc_any & is_vppn_code(code);
            commit.tlb_refill <= exc_any & (code == exp_tlbr);
            commit.is_int     <= cpu_interrupt;
        end
    end

    // payload, qualified by the wen bits above
    always_ff @(posedge clk) begin
        commit.era   <= pc0;
        commit.ecode <= code;
        commit.badv  <= exc.badv;
        // vppn is the 8k page number of the faulting address
        commit.vppn  <= exc.badv[31:13];
    end

    // refill goes to its own entry, everything else to eentry
    assign redirect_pc = commit.tlb_refill ? tlbrentry : eentry;

endmodule

//--- wb_stage/wb_lane_select.sv
`timescale 1ns/1ps

module wb_lane_select (
    input  logic                    clk,
    input  logic                    aresetn,
    input  wb_pkg::issue_t          lane0,
    input  wb_pkg::issue_t          lane1,
    input  logic                    exc_valid,
    input  logic                    cpu_interrupt,
    input  logic                    flush,
    input  logic [wb_pkg::xlen-1:0] dcache_data,
    input  logic                    dcache_ready,
    input  logic [wb_pkg::xlen-1:0] csr_data,
    output logic                    allowin,
    output wb_pkg::wb_write_t       wr0,
    output wb_pkg::wb_write_t       wr1,
    output logic [wb_pkg::xlen-1:0] pc0_q,
    output logic [wb_pkg::xlen-1:0] inst0_q,
    output logic [wb_pkg::xlen-1:0] pc1_q,
    output logic [wb_pkg::xlen-1:0] inst1_q
);
    import wb_pkg::*;

    // writeback value mux, shared by both lanes
    function automatic logic [xlen-1:0] pick_data(
        input src_kind_t       kind,
        input logic [xlen-1:0] result,
        input logic [xlen-1:0] load_data,
        input logic [xlen-1:0] csr_rd
    );
        logic [xlen-1:0] data;
        case (kind)
            src_alu:  data = result;
            // bl / jirl write the return address
            src_link: data = result + 32'd4;
            src_load: data = load_data;
            src_csr:  data = csr_rd;
            default:  data = result;
        endcase
        return data;
    endfunction

    logic            load_wait;
    logic            kill;
    logic            we0_next;
    logic            we1_next;
    logic [xlen-1:0] data0_next;
    logic [xlen-1:0] data1_next;

    // lane 0 load still waiting on the dcache
    assign load_wait = lane0.valid && (lane0.kind == src_load) && !dcache_ready;

    // back-pressure to ex1, comb and never gated by reset
    assign allowin = !load_wait;

    // exception this cycle or flush from the previous one
    assign kill = exc_valid | cpu_interrupt | flush;

    assign we0_next = lane0.valid & allowin & ~kill;

    // no load path on lane 1
    assign we1_next = lane1.valid & (lane1.kind != src_load) & allowin & ~kill;

    assign data0_next = pick_data(lane0.kind, lane0.result, dcache_data, csr_data);
    assign data1_next = pick_data(lane1.kind, lane1.result, dcache_data, csr_data);

    // write enables
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wr0.we <= 1'b0;
            wr1.we <= 1'b0;
        end else begin
            wr0.we <= we0_next;
            wr1.we <= we1_next;
        end
    end

    // write payload, only meaningful while we is high
    always_ff @(posedge clk) begin
        wr0.rd   <= lane0.rd;
        wr0.data <= data0_next;
        wr1.rd   <= lane1.rd;
        wr1.data <= data1_next;
    end

    // pc and inst for the debug trace
    // held steady upstream during a stall so they stay aligned
    always_ff @(posedge clk) begin
        pc0_q   <= lane0.pc;
        inst0_q <= lane0.inst;
        pc1_q   <= lane1.pc;
        inst1_q <= lane1.inst;
    end

endmodule

//--- common/wb_pkg.sv
package wb_pkg;

    // datapath and register widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int ecode_w    = 7;

    // andi r0, r0, 0
    localparam logic [xlen-1:0] inst_nop = 32'h0340_0000;

    // where a lane's writeback value comes from
    typedef enum logic [1:0] {
        src_alu  = 2'd0,
        src_link = 2'd1,
        src_load = 2'd2,
        src_csr  = 2'd3
    } src_kind_t;

    // estat ecode values
    localparam logic [ecode_w-1:0] exp_int  = 7'h00;
    localparam logic [ecode_w-1:0] exp_pil  = 7'h01;
    localparam logic [ecode_w-1:0] exp_pis  = 7'h02;
    localparam logic [ecode_w-1:0] exp_pif  = 7'h03;
    localparam logic [ecode_w-1:0] exp_pme  = 7'h04;
    localparam logic [ecode_w-1:0] exp_ppi  = 7'h07;
    localparam logic [ecode_w-1:0] exp_adef = 7'h08;
    localparam logic [ecode_w-1:0] exp_ale  = 7'h09;
    localparam logic [ecode_w-1:0] exp_sys  = 7'h0b;
    localparam logic [ecode_w-1:0] exp_brk  = 7'h0c;
    localparam logic [ecode_w-1:0] exp_ine  = 7'h0d;
    localparam logic [ecode_w-1:0] exp_tlbr = 7'h3f;

    // one lane of the issue bundle from ex1
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
        logic [reg_addr_w-1:0] rd;
        src_kind_t             kind;
        logic [xlen-1:0]       result;
    } issue_t;

    // lane 0 exception from earlier stages
    typedef struct packed {
        logic               valid;
        logic [ecode_w-1:0] ecode;
        logic [xlen-1:0]    badv;
    } exc_in_t;

    // register file write port
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_write_t;

    // record handed to the csr file on an exception
    typedef struct packed {
        logic               flush;
        logic               wen_badv;
        logic [xlen-1:0]    badv;
        logic               wen_vppn;
        logic [18:0]        vppn;
        logic               wen_era;
        logic [xlen-1:0]    era;
        logic [ecode_w-1:0] ecode;
        logic               tlb_refill;
        logic               is_int;
    } exc_commit_t;

    // address faults that latch badv
    function automatic logic is_badv_code(input logic [ecode_w-1:0] code);
        return (code == exp_pil) || (code == exp_pis) || (code == exp_pif) ||
               (code == exp_pme) || (code == exp_ppi) || (code == exp_adef) ||
               (code == exp_ale) || (code == exp_tlbr);
    endfunction

    // tlb related faults only, adef and ale excluded
    function automatic logic is_vppn_code(input logic [ecode_w-1:0] code);
        return (code == exp_pil) || (code == exp_pis) || (code == exp_pif) ||
               (code == exp_pme) || (code == exp_ppi) || (code == exp_tlbr);
    endfunction

endpackage
